/* fabric_pkg.sv */
// Shared types and register addresses for the dataflow tile, imported by the RTL and testbench
package fabric_pkg;

  // ----------------------------------------
  // ALU opcodes
  // ----------------------------------------

  // Three-bit opcode held in the configuration register
  // Codes 6 and 7 are undefined and make the ALU produce zero
  typedef enum logic [2:0] {
    // Operand plus constant
    OP_ADD  = 3'd0,
    // Operand minus constant
    OP_SUB  = 3'd1,
    // Low half of the operand times constant product
    OP_MUL  = 3'd2,
    // Bitwise and of operand and constant
    OP_AND  = 3'd3,
    // Bitwise xor of operand and constant
    OP_XOR  = 3'd4,
    // Constant alone, operand is consumed and dropped
    OP_PASS = 3'd5
  } pe_op_t;

  // ----------------------------------------
  // Configuration controller states
  // ----------------------------------------

  typedef enum logic [1:0] {
    // Stopped, register writes accepted
    CFG_LOAD  = 2'd0,
    // Datapath fires on every join
    CFG_RUN   = 2'd1,
    // No new fires, waiting for results in flight to leave
    CFG_DRAIN = 2'd2
  } cfg_state_t;

  // ----------------------------------------
  // Configuration register map
  // ----------------------------------------

  // Constant value, low DATA_WIDTH bits of the write data
  localparam logic [1:0] CFG_ADDR_CONST = 2'd0;
  // Output tag, low TAG_WIDTH bits of the write data
  localparam logic [1:0] CFG_ADDR_TAG   = 2'd1;
  // Opcode, low three bits of the write data
  localparam logic [1:0] CFG_ADDR_OP    = 2'd2;
  // Address 3 has no register behind it

endpackage

/* fabric_pe_constant.sv */
// Constant PE that answers each trigger token with the configured tag and constant
module fabric_pe_constant #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 4,
  localparam int PAYLOAD_WIDTH = DATA_WIDTH + TAG_WIDTH,
  localparam int SAFE_TW       = (TAG_WIDTH > 0) ? TAG_WIDTH : 1
) (
  input  logic                     clk,
  input  logic                     reset,

  // Trigger token, no payload
  input  logic                     in_valid,
  output logic                     in_ready,

  // Configured constant and tag from the controller
  input  logic [DATA_WIDTH-1:0]    const_value,
  input  logic [SAFE_TW-1:0]       const_tag,

  // Tagged constant toward the ALU
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [PAYLOAD_WIDTH-1:0] out_data
);

  // ----------------------------------------
  // Parameter checks at elaboration
  // ----------------------------------------
  initial begin : param_check
    if (DATA_WIDTH < 1)
      $fatal(1, "fabric_pe_constant: DATA_WIDTH must be at least 1");
    if (TAG_WIDTH < 0)
      $fatal(1, "fabric_pe_constant: TAG_WIDTH must not be negative");
  end

  // One constant per trigger, handshake passes straight through
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  // Tag sits in the upper bits when present
  generate
    if (TAG_WIDTH > 0) begin : g_tagged
      assign out_data = {const_tag, const_value};
    end else begin : g_native
      assign out_data = const_value;
    end
  endgenerate

endmodule

/* fabric_pe_alu.sv */
// Join PE that combines one operand with one tagged constant through a registered ALU stage
module fabric_pe_alu import fabric_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 4,
  localparam int PAYLOAD_WIDTH = DATA_WIDTH + TAG_WIDTH
) (
  input  logic                     clk,
  input  logic                     reset,

  // Control from the configuration controller
  input  logic                     run_enable,
  input  pe_op_t                   alu_op,

  // Tagged constant from the constant PE
  input  logic                     const_valid,
  output logic                     const_ready,
  input  logic [PAYLOAD_WIDTH-1:0] const_data,

  // Operand stream
  input  logic                     a_valid,
  output logic                     a_ready,
  input  logic [DATA_WIDTH-1:0]    a_data,

  // Tagged result toward the FIFO
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [PAYLOAD_WIDTH-1:0] out_data,

  // High while the output register holds a result
  output logic                     busy
);

  logic                     fire;
  logic [DATA_WIDTH-1:0]    const_field;
  logic [DATA_WIDTH-1:0]    op_result;
  logic [PAYLOAD_WIDTH-1:0] result_word;

  // ----------------------------------------
  // Join and fire
  // ----------------------------------------

  // Both tokens present and the output slot free or leaving this cycle
  assign fire = run_enable && const_valid && a_valid && (!out_valid || out_ready);

  // Both inputs are consumed together on a fire
  assign const_ready = fire;
  assign a_ready     = fire;

  // ----------------------------------------
  // Operation on the data field
  // ----------------------------------------
  assign const_field = const_data[DATA_WIDTH-1:0];

  always_comb begin
    case (alu_op)
      OP_ADD:  op_result = a_data + const_field;
      OP_SUB:  op_result = a_data - const_field;
      // Product truncated to the operand width
      OP_MUL:  op_result = a_data * const_field;
      OP_AND:  op_result = a_data & const_field;
      OP_XOR:  op_result = a_data ^ const_field;
      OP_PASS: op_result = const_field;
      // Undefined codes
      default: op_result = '0;
    endcase
  end

  // Tag of the constant rides along unchanged
  generate
    if (TAG_WIDTH > 0) begin : g_tagged
      assign result_word = {const_data[PAYLOAD_WIDTH-1:DATA_WIDTH], op_result};
    end else begin : g_native
      assign result_word = op_result;
    end
  endgenerate

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload only loads on a fire
  always_ff @(posedge clk) begin
    if (fire) begin
      out_data <= result_word;
    end
  end

  assign busy = out_valid;

endmodule

/* fabric_fifo.sv */
// Circular-buffer FIFO with valid/ready on both sides, buffers tagged results at the tile output
module fabric_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 4,
  parameter int FIFO_DEPTH = 4,
  localparam int WORD_WIDTH = DATA_WIDTH + TAG_WIDTH,
  localparam int PTR_WIDTH  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int CNT_WIDTH  = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                  clk,
  input  logic                  reset,

  // Write side
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [WORD_WIDTH-1:0] in_data,

  // Read side, head word is always on out_data
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [WORD_WIDTH-1:0] out_data,

  // No words stored
  output logic                  empty
);

  // Pointers wrap on their own, which needs a power-of-two depth
  initial begin : param_check
    if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
      $fatal(1, "fabric_fifo: FIFO_DEPTH must be a power of two, at least 2");
  end

  logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  // ----------------------------------------
  // Status and handshake
  // ----------------------------------------
  assign full      = (count == CNT_WIDTH'(FIFO_DEPTH));
  assign empty     = (count == '0);
  assign out_valid = !empty;
  // Full still takes a word when the head leaves in the same cycle
  assign in_ready  = !full || out_ready;

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  assign out_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous read and write leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* fabric_cfg_ctrl.sv */
// Configuration controller holding constant, tag and opcode, sequencing load, run and drain
module fabric_cfg_ctrl import fabric_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 4,
  localparam int SAFE_TW = (TAG_WIDTH > 0) ? TAG_WIDTH : 1
) (
  input  logic                  clk,
  input  logic                  reset,

  // Register write port and run commands
  input  logic                  cfg_valid,
  input  logic [1:0]            cfg_addr,
  input  logic [DATA_WIDTH-1:0] cfg_wdata,
  input  logic                  cfg_start,
  input  logic                  cfg_stop,

  // Datapath status used for drain
  input  logic                  alu_busy,
  input  logic                  fifo_empty,

  // Configuration toward the datapath
  output logic [DATA_WIDTH-1:0] const_value,
  output logic [SAFE_TW-1:0]    const_tag,
  output pe_op_t                alu_op,
  output logic                  run_enable,
  output logic                  running
);

  // Opcode and tag fields are cut from the write data
  initial begin : param_check
    if (DATA_WIDTH < $bits(pe_op_t))
      $fatal(1, "fabric_cfg_ctrl: DATA_WIDTH too narrow for the opcode");
    if (TAG_WIDTH > DATA_WIDTH)
      $fatal(1, "fabric_cfg_ctrl: TAG_WIDTH must not exceed DATA_WIDTH");
  end

  cfg_state_t state;
  logic       wr_accept;

  // ----------------------------------------
  // Run sequencing
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CFG_LOAD;
    end else begin
      case (state)
        CFG_LOAD: begin
          if (cfg_start) state <= CFG_RUN;
        end
        CFG_RUN: begin
          if (cfg_stop) state <= CFG_DRAIN;
        end
        CFG_DRAIN: begin
          // Nothing left in the ALU register or the FIFO
          if (!alu_busy && fifo_empty) state <= CFG_LOAD;
        end
        default: state <= CFG_LOAD;
      endcase
    end
  end

  // New fires only in RUN, results still leave during DRAIN
  assign run_enable = (state == CFG_RUN);
  assign running    = (state != CFG_LOAD);

  // ----------------------------------------
  // Configuration registers
  // ----------------------------------------

  // Writes outside LOAD are dropped
  assign wr_accept = cfg_valid && (state == CFG_LOAD);

  always_ff @(posedge clk) begin
    if (reset) begin
      const_value <= '0;
      const_tag   <= '0;
      alu_op      <= OP_PASS;
    end else if (wr_accept) begin
      case (cfg_addr)
        CFG_ADDR_CONST: const_value <= cfg_wdata;
        CFG_ADDR_TAG:   const_tag   <= cfg_wdata[SAFE_TW-1:0];
        // Undefined codes are stored as written
        CFG_ADDR_OP:    alu_op      <= pe_op_t'(cfg_wdata[$bits(pe_op_t)-1:0]);
        default: ;
      endcase
    end
  end

endmodule

/* fabric_tile.sv */
// Top level of the dataflow tile, wiring the controller, constant PE, ALU PE and output FIFO
module fabric_tile import fabric_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int TAG_WIDTH  = 4,
  parameter int FIFO_DEPTH = 4,
  localparam int PAYLOAD_WIDTH = DATA_WIDTH + TAG_WIDTH,
  localparam int SAFE_TW       = (TAG_WIDTH > 0) ? TAG_WIDTH : 1
) (
  input  logic                     clk,
  input  logic                     reset,

  // Configuration
  input  logic                     cfg_valid,
  input  logic [1:0]               cfg_addr,
  input  logic [DATA_WIDTH-1:0]    cfg_wdata,
  input  logic                     cfg_start,
  input  logic                     cfg_stop,
  output logic                     running,

  // Trigger stream, no payload
  input  logic                     trig_valid,
  output logic                     trig_ready,

  // Operand stream
  input  logic                     a_valid,
  output logic                     a_ready,
  input  logic [DATA_WIDTH-1:0]    a_data,

  // Result stream, tag in the upper bits
  output logic                     res_valid,
  input  logic                     res_ready,
  output logic [PAYLOAD_WIDTH-1:0] res_data
);

  // Controller to datapath
  logic [DATA_WIDTH-1:0]    const_value;
  logic [SAFE_TW-1:0]       const_tag;
  pe_op_t                   alu_op;
  logic                     run_enable;

  // Datapath status back to the controller
  logic                     alu_busy;
  logic                     fifo_empty;

  // Constant PE to ALU
  logic                     const_valid;
  logic                     const_ready;
  logic [PAYLOAD_WIDTH-1:0] const_data;

  // ALU to FIFO
  logic                     alu_valid;
  logic                     alu_ready;
  logic [PAYLOAD_WIDTH-1:0] alu_data;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  fabric_cfg_ctrl #(
    .DATA_WIDTH(DATA_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_cfg (
    .clk        (clk),
    .reset      (reset),
    .cfg_valid  (cfg_valid),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_start  (cfg_start),
    .cfg_stop   (cfg_stop),
    .alu_busy   (alu_busy),
    .fifo_empty (fifo_empty),
    .const_value(const_value),
    .const_tag  (const_tag),
    .alu_op     (alu_op),
    .run_enable (run_enable),
    .running    (running)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  // Trigger side
  fabric_pe_constant #(
    .DATA_WIDTH(DATA_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_const (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (trig_valid),
    .in_ready   (trig_ready),
    .const_value(const_value),
    .const_tag  (const_tag),
    .out_valid  (const_valid),
    .out_ready  (const_ready),
    .out_data   (const_data)
  );

  // Join of constant and operand
  fabric_pe_alu #(
    .DATA_WIDTH(DATA_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_alu (
    .clk        (clk),
    .reset      (reset),
    .run_enable (run_enable),
    .alu_op     (alu_op),
    .const_valid(const_valid),
    .const_ready(const_ready),
    .const_data (const_data),
    .a_valid    (a_valid),
    .a_ready    (a_ready),
    .a_data     (a_data),
    .out_valid  (alu_valid),
    .out_ready  (alu_ready),
    .out_data   (alu_data),
    .busy       (alu_busy)
  );

  // Output buffer absorbing res_ready back-pressure
  fabric_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .TAG_WIDTH (TAG_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_valid (alu_valid),
    .in_ready (alu_ready),
    .in_data  (alu_data),
    .out_valid(res_valid),
    .out_ready(res_ready),
    .out_data (res_data),
    .empty    (fifo_empty)
  );

endmodule

/* tb_fabric_tile.sv */
// Self-checking testbench for the dataflow tile, runs a table of tests with random back-pressure
module tb_fabric_tile
  import fabric_pkg::*;
();

  localparam int DATA_WIDTH = 16;
  localparam int TAG_WIDTH  = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int WORD_WIDTH = TAG_WIDTH + DATA_WIDTH;
  localparam int NUM_TESTS  = 9;
  localparam logic [DATA_WIDTH-1:0] STEP = 16'h0137;

  // ----------------------------------------
  // Test table
  // ----------------------------------------
  // Codes 6 and 7 are undefined and must give zero
  localparam logic [2:0] TEST_OP [NUM_TESTS] = '{
    OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_XOR, OP_PASS, 3'd6, OP_ADD, OP_XOR};
  localparam logic [DATA_WIDTH-1:0] TEST_CONST [NUM_TESTS] = '{
    16'h1234, 16'h0050, 16'h0123, 16'h0ff0, 16'ha5a5, 16'hbeef, 16'hffff, 16'h0001, 16'h3c3c};
  localparam logic [TAG_WIDTH-1:0] TEST_TAG [NUM_TESTS] = '{
    4'h3, 4'h5, 4'h9, 4'ha, 4'hc, 4'hf, 4'h1, 4'h2, 4'h6};
  localparam int TEST_COUNT [NUM_TESTS] = '{6, 6, 6, 6, 8, 5, 5, 12, 8};
  localparam logic [DATA_WIDTH-1:0] TEST_START [NUM_TESTS] = '{
    16'h0100, 16'h0020, 16'h0101, 16'h1357, 16'h5a00, 16'h0007, 16'h4321, 16'hfff8, 16'h0f0f};
  // Entries that also try register writes while running
  localparam logic TEST_POKE [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};

  logic                  clk;
  logic                  reset;
  logic                  cfg_valid;
  logic [1:0]            cfg_addr;
  logic [DATA_WIDTH-1:0] cfg_wdata;
  logic                  cfg_start;
  logic                  cfg_stop;
  logic                  running;
  logic                  trig_valid;
  logic                  trig_ready;
  logic                  a_valid;
  logic                  a_ready;
  logic [DATA_WIDTH-1:0] a_data;
  logic                  res_valid;
  logic                  res_ready;
  logic [WORD_WIDTH-1:0] res_data;

  // Scoreboard and bookkeeping
  logic [WORD_WIDTH-1:0] exp_q [$];
  logic [WORD_WIDTH-1:0] exp_word;
  logic [31:0]           lcg_state;
  int                    errors;
  int                    test_errors;
  int                    results;
  int                    tests_done;
  int                    total_ops;
  int                    cycles;
  int                    cycle_limit;

  fabric_tile #(
    .DATA_WIDTH(DATA_WIDTH),
    .TAG_WIDTH (TAG_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk       (clk),
    .reset     (reset),
    .cfg_valid (cfg_valid),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_start (cfg_start),
    .cfg_stop  (cfg_stop),
    .running   (running),
    .trig_valid(trig_valid),
    .trig_ready(trig_ready),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

  always #10 clk = ~clk;

  // ----------------------------------------
  // Reference model and random source
  // ----------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Tag on top, opcode result below
  function automatic logic [WORD_WIDTH-1:0] expected_word(input logic [2:0] op,
      input logic [DATA_WIDTH-1:0] k, input logic [TAG_WIDTH-1:0] tag,
      input logic [DATA_WIDTH-1:0] a);
    logic [2*DATA_WIDTH-1:0] prod;
    logic [DATA_WIDTH-1:0]   value;
    prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, k};
    case (op)
      OP_ADD:  value = a + k;
      OP_SUB:  value = a - k;
      OP_MUL:  value = prod[DATA_WIDTH-1:0];
      OP_AND:  value = a & k;
      OP_XOR:  value = a ^ k;
      OP_PASS: value = k;
      default: value = '0;
    endcase
    return {tag, value};
  endfunction

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  // Random res_ready, low half the time so the FIFO fills
  always @(posedge clk) begin
    lcg_state = lcg_next(lcg_state);
    res_ready <= lcg_state[31];
  end

  // Cycle limit against a hung run
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // In-order result check on every transfer
  always @(posedge clk) begin
    if (!reset && res_valid && res_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("result %h arrived with no result outstanding", res_data);
        note_error();
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        results++;
        assert (res_data == exp_word) else begin
          $display("mismatch res_data: got %h expected %h", res_data, exp_word);
          note_error();
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus tasks, called just after a rising edge
  // ----------------------------------------
  task automatic write_cfg(input logic [1:0] addr, input logic [DATA_WIDTH-1:0] data);
    cfg_valid <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_valid <= 1'b0;
  endtask

  task automatic pulse_start();
    cfg_start <= 1'b1;
    @(posedge clk);
    cfg_start <= 1'b0;
  endtask

  task automatic pulse_stop();
    cfg_stop <= 1'b1;
    @(posedge clk);
    cfg_stop <= 1'b0;
  endtask

  // Trigger and operand go together, held until the join fires
  task automatic send_operand(input logic [DATA_WIDTH-1:0] value,
      input logic [WORD_WIDTH-1:0] exp_value);
    trig_valid <= 1'b1;
    a_valid    <= 1'b1;
    a_data     <= value;
    @(posedge clk);
    while (!(trig_ready && a_ready)) @(posedge clk);
    exp_q.push_back(exp_value);
  endtask

  // Drain must not end while results are still owed
  task automatic wait_idle();
    @(posedge clk);
    while (running) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      $display("running fell with %0d results still outstanding", exp_q.size());
      note_error();
    end
  endtask

  // Stopped tile offered tokens must refuse them
  task automatic check_idle_reject();
    test_errors = 0;
    trig_valid <= 1'b1;
    a_valid    <= 1'b1;
    a_data     <= 16'h0bad;
    repeat (8) begin
      @(posedge clk);
      assert (!trig_ready && !a_ready && !running) else begin
        $display("tile accepted a token or ran without cfg_start");
        note_error();
      end
      assert (!res_valid) else begin
        $display("result appeared without cfg_start");
        note_error();
      end
    end
    trig_valid <= 1'b0;
    a_valid    <= 1'b0;
    tests_done++;
    $display("test %0d stopped tile rejects tokens: %0s", tests_done,
             (test_errors == 0) ? "ok" : "failed");
  endtask

  task automatic run_entry(input int idx);
    logic [DATA_WIDTH-1:0] operand;
    test_errors = 0;
    write_cfg(CFG_ADDR_CONST, TEST_CONST[idx]);
    write_cfg(CFG_ADDR_TAG, DATA_WIDTH'(TEST_TAG[idx]));
    write_cfg(CFG_ADDR_OP, DATA_WIDTH'(TEST_OP[idx]));
    pulse_start();
    // Writes in RUN, the tile has to keep the earlier values
    if (TEST_POKE[idx]) begin
      write_cfg(CFG_ADDR_CONST, ~TEST_CONST[idx]);
      write_cfg(CFG_ADDR_TAG, DATA_WIDTH'(~TEST_TAG[idx]));
      write_cfg(CFG_ADDR_OP, DATA_WIDTH'(OP_MUL));
    end
    operand = TEST_START[idx];
    for (int i = 0; i < TEST_COUNT[idx]; i++) begin
      send_operand(operand, expected_word(TEST_OP[idx], TEST_CONST[idx], TEST_TAG[idx],
                                          operand));
      operand = operand + STEP;
    end
    trig_valid <= 1'b0;
    a_valid    <= 1'b0;
    pulse_stop();
    wait_idle();
    tests_done++;
    $display("test %0d op %0d const %h tag %h, %0d operands: %0s", tests_done, TEST_OP[idx],
             TEST_CONST[idx], TEST_TAG[idx], TEST_COUNT[idx],
             (test_errors == 0) ? "ok" : "failed");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    cfg_valid   = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    cfg_start   = 1'b0;
    cfg_stop    = 1'b0;
    trig_valid  = 1'b0;
    a_valid     = 1'b0;
    a_data      = '0;
    res_ready   = 1'b0;
    lcg_state   = 32'he2cb_6973;
    errors      = 0;
    test_errors = 0;
    results     = 0;
    tests_done  = 0;
    cycles      = 0;
    total_ops   = 0;
    for (int i = 0; i < NUM_TESTS; i++) total_ops += TEST_COUNT[i];
    cycle_limit = 200 + 30 * total_ops;

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    check_idle_reject();
    for (int i = 0; i < NUM_TESTS; i++) run_entry(i);

    // Every operand sent must have come back exactly once
    assert (results == total_ops) else begin
      $display("received %0d results for %0d operands", results, total_ops);
      errors++;
    end

    $display("tests %0d results %0d errors %0d", tests_done, results, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* files.f */
fabric_pkg.sv
fabric_pe_constant.sv
fabric_pe_alu.sv
fabric_fifo.sv
fabric_cfg_ctrl.sv
fabric_tile.sv
tb_fabric_tile.sv

/* run.sh */
#!/bin/sh
# Builds the tile testbench with Verilator, runs it and checks the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fabric_tile \
  -f files.f -o sim_fabric_tile > build.log 2>&1 \
  && ./obj_dir/sim_fabric_tile > sim.log 2>&1 \
  && ! grep -q "=== FAIL ===" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

exit 0
